// ==== hdl/warblade_pkg.sv ====
//////////////////////////////
// Warblade shared definitions
// Frame geometry, sprite sizes, colours and pixel types
//////////////////////////////

package warblade_pkg;

  typedef logic [6:0]  coord_t;   // hcount, vcount and sprite positions
  typedef logic [11:0] rgb_t;     // r in [11:8], g in [7:4], b in [3:0]
  typedef logic [3:0]  level_t;

  // Horizontal timing in pixel clocks
  localparam coord_t H_ACTIVE = 7'd64;
  localparam coord_t H_FP     = 7'd4;
  localparam coord_t H_SYNC   = 7'd8;
  localparam coord_t H_BP     = 7'd4;
  localparam coord_t H_TOTAL  = 7'd80;

  // Vertical timing in lines
  localparam coord_t V_ACTIVE = 7'd48;
  localparam coord_t V_FP     = 7'd2;
  localparam coord_t V_SYNC   = 7'd3;
  localparam coord_t V_BP     = 7'd3;
  localparam coord_t V_TOTAL  = 7'd56;

  // Sync windows
  localparam coord_t H_SYNC_START = H_ACTIVE + H_FP;
  localparam coord_t H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam coord_t V_SYNC_START = V_ACTIVE + V_FP;
  localparam coord_t V_SYNC_END   = V_SYNC_START + V_SYNC;

  // Player ship
  localparam coord_t SHIP_W       = 7'd8;
  localparam coord_t SHIP_H       = 7'd4;
  localparam coord_t SHIP_Y       = 7'd40;
  localparam coord_t SHIP_X_RESET = 7'd28;
  localparam coord_t SHIP_STEP    = 7'd2;
  localparam coord_t SHIP_X_MAX   = H_ACTIVE - SHIP_W;

  // Missile, one pixel wide
  localparam coord_t MISSILE_H     = 7'd2;
  localparam coord_t MISSILE_STEP  = 7'd4;
  localparam coord_t MISSILE_X_OFS = 7'd3;  // Nose of the ship

  localparam rgb_t SHIP_RGB      = 12'h0e3;
  localparam rgb_t MISSILE_RGB   = 12'hf50;
  localparam rgb_t STAR_BASE_RGB = 12'haa4;

  // Sanity relation kept visible for the geometry above
  localparam coord_t H_CHECK = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam coord_t V_CHECK = V_ACTIVE + V_FP + V_SYNC + V_BP;

endpackage

// ==== hdl/vga_if.sv ====
//////////////////////////////
// Pixel stream link
// One pixel per clock between drawing stages
//////////////////////////////

`timescale 1ns/100ps

interface vga_if;

  warblade_pkg::coord_t hcount;
  warblade_pkg::coord_t vcount;
  logic                 hsync;
  logic                 vsync;
  logic                 hblnk;
  logic                 vblnk;
  warblade_pkg::rgb_t   rgb;

  // Driving stage
  modport src (
    output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

  // Reading stage
  modport snk (
    input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

endinterface

// ==== hdl/vga_timing.sv ====
//////////////////////////////
// VGA timing generator
// Counters, sync and blanking for the small frame
//////////////////////////////

`timescale 1ns/100ps

module vga_timing (
  input  logic pclk,
  input  logic reset_i,
  vga_if.src   vid_o
);

  warblade_pkg::coord_t hcount_q, vcount_q;
  warblade_pkg::coord_t hcount_nxt, vcount_nxt;
  logic hsync_q, vsync_q;
  logic hblnk_q, vblnk_q;
  logic line_end;

  assign line_end = (hcount_q == warblade_pkg::H_TOTAL - warblade_pkg::coord_t'(1));

  always_comb begin
    if (line_end) begin
      hcount_nxt = '0;
      if (vcount_q == warblade_pkg::V_TOTAL - warblade_pkg::coord_t'(1)) begin
        vcount_nxt = '0;
      end else begin
        vcount_nxt = vcount_q + warblade_pkg::coord_t'(1);
      end
    end else begin
      hcount_nxt = hcount_q + warblade_pkg::coord_t'(1);
      vcount_nxt = vcount_q;
    end
  end

  // Decode from the next count so flags line up with the counters
  always_ff @(posedge pclk) begin
    if (reset_i) begin
      hcount_q <= '0;
      vcount_q <= '0;
      hsync_q  <= 1'b0;
      vsync_q  <= 1'b0;
      hblnk_q  <= 1'b0;
      vblnk_q  <= 1'b0;
    end else begin
      hcount_q <= hcount_nxt;
      vcount_q <= vcount_nxt;
      hsync_q  <= (hcount_nxt >= warblade_pkg::H_SYNC_START) &&
                  (hcount_nxt <  warblade_pkg::H_SYNC_END);
      vsync_q  <= (vcount_nxt >= warblade_pkg::V_SYNC_START) &&
                  (vcount_nxt <  warblade_pkg::V_SYNC_END);
      hblnk_q  <= (hcount_nxt >= warblade_pkg::H_ACTIVE);
      vblnk_q  <= (vcount_nxt >= warblade_pkg::V_ACTIVE);
    end
  end

  assign vid_o.hcount = hcount_q;
  assign vid_o.vcount = vcount_q;
  assign vid_o.hsync  = hsync_q;
  assign vid_o.vsync  = vsync_q;
  assign vid_o.hblnk  = hblnk_q;
  assign vid_o.vblnk  = vblnk_q;
  assign vid_o.rgb    = '0;     // Colour comes from the stages

endmodule

// ==== hdl/draw_background.sv ====
//////////////////////////////
// Background stage
// Blanking and a level-coloured star field
//////////////////////////////

`timescale 1ns/100ps

module draw_background (
  input  logic                 pclk,
  input  logic                 reset_i,
  input  warblade_pkg::level_t level_i,
  vga_if.snk                   vid_i,
  vga_if.src                   vid_o
);

  warblade_pkg::level_t level_q;
  warblade_pkg::rgb_t   star_rgb;
  logic frame_upd;
  logic visible;
  logic star_hit;

  assign frame_upd = (vid_i.vcount == warblade_pkg::V_ACTIVE) && (vid_i.hcount == '0);
  assign visible   = !(vid_i.hblnk || vid_i.vblnk);

  // Diagonal dots, phase picked by the level
  assign star_hit = (vid_i.hcount[2:0] == vid_i.vcount[2:0]) &&
                    (vid_i.hcount[2:0] == level_q[2:0]);

  assign star_rgb = {warblade_pkg::STAR_BASE_RGB[11:4],
                     warblade_pkg::STAR_BASE_RGB[3:0] + level_q};  // Blue wraps

  always_ff @(posedge pclk) begin
    if (reset_i) begin
      level_q      <= '0;
      vid_o.hcount <= '0;
      vid_o.vcount <= '0;
      vid_o.hsync  <= 1'b0;
      vid_o.vsync  <= 1'b0;
      vid_o.hblnk  <= 1'b0;
      vid_o.vblnk  <= 1'b0;
      vid_o.rgb    <= '0;
    end else begin
      if (frame_upd) level_q <= level_i;
      vid_o.hcount <= vid_i.hcount;
      vid_o.vcount <= vid_i.vcount;
      vid_o.hsync  <= vid_i.hsync;
      vid_o.vsync  <= vid_i.vsync;
      vid_o.hblnk  <= vid_i.hblnk;
      vid_o.vblnk  <= vid_i.vblnk;
      vid_o.rgb    <= (visible && star_hit) ? star_rgb : '0;
    end
  end

endmodule

// ==== hdl/draw_ship.sv ====
//////////////////////////////
// Ship stage
// Moves the player ship once per frame and draws it
//////////////////////////////

`timescale 1ns/100ps

module draw_ship (
  input  logic                 pclk,
  input  logic                 reset_i,
  input  logic                 left_i,
  input  logic                 right_i,
  vga_if.snk                   vid_i,
  vga_if.src                   vid_o,
  output warblade_pkg::coord_t ship_x_o
);

  warblade_pkg::coord_t ship_x;
  warblade_pkg::coord_t ship_x_nxt;
  logic left_flag, right_flag;
  logic frame_upd;
  logic visible;
  logic ship_hit;

  assign frame_upd = (vid_i.vcount == warblade_pkg::V_ACTIVE) && (vid_i.hcount == '0);
  assign visible   = !(vid_i.hblnk || vid_i.vblnk);

  // Step with clamping at both edges
  always_comb begin
    ship_x_nxt = ship_x;
    if (left_flag && !right_flag) begin
      if (ship_x < warblade_pkg::SHIP_STEP) begin
        ship_x_nxt = '0;
      end else begin
        ship_x_nxt = ship_x - warblade_pkg::SHIP_STEP;
      end
    end else if (right_flag && !left_flag) begin
      if (ship_x > warblade_pkg::SHIP_X_MAX - warblade_pkg::SHIP_STEP) begin
        ship_x_nxt = warblade_pkg::SHIP_X_MAX;
      end else begin
        ship_x_nxt = ship_x + warblade_pkg::SHIP_STEP;
      end
    end
  end

  assign ship_hit = visible &&
                    (vid_i.hcount >= ship_x) &&
                    (vid_i.hcount <  ship_x + warblade_pkg::SHIP_W) &&
                    (vid_i.vcount >= warblade_pkg::SHIP_Y) &&
                    (vid_i.vcount <  warblade_pkg::SHIP_Y + warblade_pkg::SHIP_H);

  always_ff @(posedge pclk) begin
    if (reset_i) begin
      ship_x     <= warblade_pkg::SHIP_X_RESET;
      left_flag  <= 1'b0;
      right_flag <= 1'b0;
    end else if (frame_upd) begin
      ship_x     <= ship_x_nxt;
      left_flag  <= 1'b0;    // New frame, new presses
      right_flag <= 1'b0;
    end else begin
      left_flag  <= left_flag | left_i;
      right_flag <= right_flag | right_i;
    end
  end

  always_ff @(posedge pclk) begin
    if (reset_i) begin
      vid_o.hcount <= '0;
      vid_o.vcount <= '0;
      vid_o.hsync  <= 1'b0;
      vid_o.vsync  <= 1'b0;
      vid_o.hblnk  <= 1'b0;
      vid_o.vblnk  <= 1'b0;
      vid_o.rgb    <= '0;
    end else begin
      vid_o.hcount <= vid_i.hcount;
      vid_o.vcount <= vid_i.vcount;
      vid_o.hsync  <= vid_i.hsync;
      vid_o.vsync  <= vid_i.vsync;
      vid_o.hblnk  <= vid_i.hblnk;
      vid_o.vblnk  <= vid_i.vblnk;
      vid_o.rgb    <= ship_hit ? warblade_pkg::SHIP_RGB : vid_i.rgb;
    end
  end

  assign ship_x_o = ship_x;

endmodule

// ==== hdl/draw_missile.sv ====
//////////////////////////////
// Missile stage
// Launches, climbs and retires the player missile
//////////////////////////////

`timescale 1ns/100ps

module draw_missile (
  input  logic                 pclk,
  input  logic                 reset_i,
  input  logic                 shoot_i,
  input  warblade_pkg::coord_t ship_x_i,
  vga_if.snk                   vid_i,
  vga_if.src                   vid_o
);

  warblade_pkg::coord_t mis_x, mis_y;
  logic mis_active;
  logic shoot_flag;
  logic frame_upd;
  logic mis_hit;

  // Lands one clock after the ship stage, ship_x_i is already updated
  assign frame_upd = (vid_i.vcount == warblade_pkg::V_ACTIVE) && (vid_i.hcount == '0);

  assign mis_hit = mis_active &&
                   (vid_i.hcount == mis_x) &&
                   (vid_i.vcount >= mis_y) &&
                   (vid_i.vcount <  mis_y + warblade_pkg::MISSILE_H);

  always_ff @(posedge pclk) begin
    if (reset_i) begin
      mis_active <= 1'b0;
      mis_x      <= '0;
      mis_y      <= '0;
      shoot_flag <= 1'b0;
    end else if (frame_upd) begin
      if (mis_active) begin
        if (mis_y < warblade_pkg::MISSILE_STEP) begin
          mis_active <= 1'b0;   // Off the top
        end else begin
          mis_y <= mis_y - warblade_pkg::MISSILE_STEP;
        end
      end else if (shoot_flag) begin
        mis_active <= 1'b1;
        mis_x      <= ship_x_i + warblade_pkg::MISSILE_X_OFS;
        mis_y      <= warblade_pkg::SHIP_Y - warblade_pkg::MISSILE_H;
      end
      // Presses while in flight are dropped
      shoot_flag <= 1'b0;
    end else begin
      shoot_flag <= shoot_flag | shoot_i;
    end
  end

  always_ff @(posedge pclk) begin
    if (reset_i) begin
      vid_o.hcount <= '0;
      vid_o.vcount <= '0;
      vid_o.hsync  <= 1'b0;
      vid_o.vsync  <= 1'b0;
      vid_o.hblnk  <= 1'b0;
      vid_o.vblnk  <= 1'b0;
      vid_o.rgb    <= '0;
    end else begin
      vid_o.hcount <= vid_i.hcount;
      vid_o.vcount <= vid_i.vcount;
      vid_o.hsync  <= vid_i.hsync;
      vid_o.vsync  <= vid_i.vsync;
      vid_o.hblnk  <= vid_i.hblnk;
      vid_o.vblnk  <= vid_i.vblnk;
      vid_o.rgb    <= mis_hit ? warblade_pkg::MISSILE_RGB : vid_i.rgb;
    end
  end

endmodule

// ==== hdl/warblade_top.sv ====
//////////////////////////////
// Warblade top level
// Timing and three drawing stages to VGA pins
//////////////////////////////

`timescale 1ns/100ps

module warblade_top (
  input  logic                 pclk,
  input  logic                 reset_i,
  input  warblade_pkg::level_t level_i,
  input  logic                 left_i,
  input  logic                 right_i,
  input  logic                 shoot_i,
  output logic                 hsync_o,
  output logic                 vsync_o,
  output logic [3:0]           r_o,
  output logic [3:0]           g_o,
  output logic [3:0]           b_o
);

  vga_if vid_t ();  // Timing only
  vga_if vid_b ();  // Background
  vga_if vid_s ();  // Plus ship
  vga_if vid_m ();  // Plus missile

  warblade_pkg::coord_t ship_x;

  vga_timing i_timing (
    .pclk    (pclk),
    .reset_i (reset_i),
    .vid_o   (vid_t)
  );

  draw_background i_background (
    .pclk    (pclk),
    .reset_i (reset_i),
    .level_i (level_i),
    .vid_i   (vid_t),
    .vid_o   (vid_b)
  );

  draw_ship i_ship (
    .pclk     (pclk),
    .reset_i  (reset_i),
    .left_i   (left_i),
    .right_i  (right_i),
    .vid_i    (vid_b),
    .vid_o    (vid_s),
    .ship_x_o (ship_x)
  );

  draw_missile i_missile (
    .pclk     (pclk),
    .reset_i  (reset_i),
    .shoot_i  (shoot_i),
    .ship_x_i (ship_x),
    .vid_i    (vid_s),
    .vid_o    (vid_m)
  );

  assign hsync_o = vid_m.hsync;
  assign vsync_o = vid_m.vsync;
  assign r_o     = vid_m.rgb[11:8];
  assign g_o     = vid_m.rgb[7:4];
  assign b_o     = vid_m.rgb[3:0];

endmodule

// ==== verif/tb_clock.sv ====
//////////////////////////////
// Testbench clock and reset
//////////////////////////////

`timescale 1ns/100ps

module tb_clock (
  output logic pclk_o,
  output logic reset_o
);

  initial begin
    pclk_o = 1'b0;
    forever #5 pclk_o = ~pclk_o;  // 10 ns period
  end

  initial begin
    reset_o = 1'b1;
    repeat (3) @(posedge pclk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== verif/warblade_tb.sv ====
//////////////////////////////
// Warblade testbench
// Pixel-exact model of the frame against the DUT
//////////////////////////////

`timescale 1ns/100ps

module warblade_tb;

  localparam int FRAME_CYC = 80 * 56;
  localparam int RUN_FRAMES = 40;
  localparam int LIMIT_CYC = (RUN_FRAMES + 2) * FRAME_CYC;

  logic pclk;
  logic reset_i;
  warblade_pkg::level_t level_i;
  logic left_i, right_i, shoot_i;
  logic hsync_o, vsync_o;
  logic [3:0] r_o, g_o, b_o;

  // Model state
  int n;             // Pixel index presented by the timing stage
  int cycles = 0;
  int h_m, v_m;
  int sx, mx, my;
  logic ma;
  logic lf, rf, sf;
  warblade_pkg::level_t lvl_m;
  logic [13:0] exp_q[$];
  logic [13:0] exp_now;
  logic [13:0] exp_old;
  logic [31:0] rnd;

  tb_clock i_clock (
    .pclk_o  (pclk),
    .reset_o (reset_i)
  );

  warblade_top i_dut (
    .pclk    (pclk),
    .reset_i (reset_i),
    .level_i (level_i),
    .left_i  (left_i),
    .right_i (right_i),
    .shoot_i (shoot_i),
    .hsync_o (hsync_o),
    .vsync_o (vsync_o),
    .r_o     (r_o),
    .g_o     (g_o),
    .b_o     (b_o)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Expected {hsync, vsync, rgb} for one pixel
  function automatic logic [13:0] ref_pixel(input int h, input int v, input logic [3:0] lvl,
                                            input int shx, input logic act, input int msx,
                                            input int msy);
    logic hs, vs, vis;
    logic [11:0] rgb;
    int blue;
    hs = (h >= 64 + 4) && (h < 64 + 4 + 8);
    vs = (v >= 48 + 2) && (v < 48 + 2 + 3);
    vis = (h < 64) && (v < 48);
    rgb = 12'h000;
    blue = (int'(warblade_pkg::STAR_BASE_RGB[3:0]) + int'(lvl)) % 16;
    if (vis && (h % 8 == v % 8) && (h % 8 == int'(lvl[2:0])))
      rgb = {warblade_pkg::STAR_BASE_RGB[11:4], 4'(blue)};
    if (vis && h >= shx && h < shx + 8 && v >= 40 && v < 44)
      rgb = warblade_pkg::SHIP_RGB;
    if (act && h == msx && v >= msy && v < msy + 2)
      rgb = warblade_pkg::MISSILE_RGB;
    return {hs, vs, rgb};
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      $display("mismatch %s at pixel %0d: got %h expected %h", name, n - 3, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "check failed");
    end
  endtask

  // Model and comparison against outputs 3 cycles behind the timing stage
  always @(posedge pclk) begin
    if (reset_i) begin
      n <= 0;
      sx = 28;
      ma = 1'b0;
      mx = 0;
      my = 0;
      lf = 1'b0;
      rf = 1'b0;
      sf = 1'b0;
      lvl_m = '0;
      exp_q = '{14'h0, 14'h0, 14'h0};
    end else begin
      h_m = n % 80;
      v_m = (n / 80) % 56;
      exp_now = ref_pixel(h_m, v_m, lvl_m, sx, ma, mx, my);
      exp_q.push_back(exp_now);
      exp_old = exp_q.pop_front();
      check_value("hsync_o", {15'h0, hsync_o}, {15'h0, exp_old[13]});
      check_value("vsync_o", {15'h0, vsync_o}, {15'h0, exp_old[12]});
      check_value("r_o", {12'h0, r_o}, {12'h0, exp_old[11:8]});
      check_value("g_o", {12'h0, g_o}, {12'h0, exp_old[7:4]});
      check_value("b_o", {12'h0, b_o}, {12'h0, exp_old[3:0]});
      if (v_m == 48 && h_m == 0) begin
        lvl_m = level_i;
        if (lf && !rf) sx = (sx - 2 < 0) ? 0 : sx - 2;
        else if (rf && !lf) sx = (sx + 2 > 56) ? 56 : sx + 2;
        if (ma) begin
          if (my < 4) ma = 1'b0;
          else my = my - 4;
        end else if (sf) begin
          ma = 1'b1;
          mx = sx + 3;
          my = 40 - 2;
        end
        lf = 1'b0;
        rf = 1'b0;
        sf = 1'b0;
      end else begin
        lf = lf | left_i;
        rf = rf | right_i;
        sf = sf | shoot_i;
      end
      n <= n + 1;
    end
  end

  always @(posedge pclk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT_CYC) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT_CYC);
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic wait_for_line(input int frame, input int line);
    while (reset_i || n < frame * FRAME_CYC + line * 80) @(posedge pclk);
  endtask

  // Buttons set at line 8 and shoot dropped at line 30
  task automatic run_frame(input int frame, input logic [3:0] lvl, input logic l,
                           input logic r, input logic s);
    wait_for_line(frame, 8);
    level_i <= lvl;
    left_i  <= l;
    right_i <= r;
    shoot_i <= s;
    wait_for_line(frame, 30);
    shoot_i <= 1'b0;
  endtask

  initial begin
    level_i = '0;
    left_i = 1'b0;
    right_i = 1'b0;
    shoot_i = 1'b0;
    rnd = 32'h0dd5fce2;
    run_frame(0, 4'd0, 1'b0, 1'b0, 1'b0);
    run_frame(1, 4'd3, 1'b0, 1'b0, 1'b0);
    run_frame(2, 4'd3, 1'b1, 1'b1, 1'b0);     // Both held, no move
    for (int f = 3; f < 19; f++) begin
      run_frame(f, 4'd3, 1'b1, 1'b0, 1'b0);   // Walk to the left edge
    end
    run_frame(19, 4'd3, 1'b0, 1'b1, 1'b1);    // Launch from the moved ship
    run_frame(20, 4'd5, 1'b0, 1'b1, 1'b1);    // Second shot ignored
    for (int f = 21; f < 30; f++) begin
      run_frame(f, (f < 25) ? 4'd5 : 4'd12, 1'b0, 1'b1, 1'b0);
    end
    for (int f = 30; f < RUN_FRAMES; f++) begin
      rnd = xorshift(rnd);
      run_frame(f, rnd[3:0], rnd[4], rnd[5], rnd[6]);
    end
    wait_for_line(RUN_FRAMES, 0);
    repeat (4) @(posedge pclk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/warblade_pkg.sv
hdl/vga_if.sv
hdl/vga_timing.sv
hdl/draw_background.sv
hdl/draw_ship.sv
hdl/draw_missile.sv
hdl/warblade_top.sv
verif/tb_clock.sv
verif/warblade_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the warblade testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f vlog.f --top-module warblade_tb -o warblade_sim \
  && ./obj_dir/warblade_sim \
  || exit 1
